/* sources.f */
hw/dec_pkg.sv
hw/dec_pause_if.sv
hw/dec_gpr_ctl.sv
hw/dec_nbload_ctl.sv
hw/dec_halt_ctl.sv
hw/dec_pause_timer.sv
hw/dec_core.sv
tests/tb_clk_gen.sv
tests/dec_props.sv
tests/tb_dec.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of tb_dec
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_dec -Mdir obj_dir

if ./obj_dir/Vtb_dec 2>&1 | tee /dev/stderr | grep -qx "NO ERRORS"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tests/tb_dec.sv */
`timescale 1ns/10ps

module tb_dec;

   localparam int NBLOAD_DEPTH = 4;
   localparam int PAUSE_W      = 16;
   localparam int TAG_W        = $clog2(NBLOAD_DEPTH);
   localparam int TIMEOUT      = 200;                 // cycles per wait

   typedef enum int {
      OP_WR, OP_RD, OP_ISS, OP_RET, OP_INV, OP_HALT,
      OP_QUIET, OP_IDLE, OP_RUN, OP_PAUSE, OP_PHALT, OP_CRD
   } op_e;

   typedef struct {
      op_e op;
      int  a;                                         // addr, tag or count
      int  b;                                         // second addr or dest
      int  c;                                         // enables, delay or lsu idle level
      int  d;                                         // fourth read addr
   } row_t;

   logic clk;
   logic rst_n;
   dec_pkg::reg_addr_t raddr0, raddr1, raddr2, raddr3;
   dec_pkg::xlen_t     rd0, rd1, rd2, rd3;
   logic               wen0, wen1;
   dec_pkg::reg_addr_t waddr0, waddr1;
   dec_pkg::xlen_t     wd0, wd1;
   logic               nbload_valid, nbload_inv_valid, nbload_data_valid;
   logic [TAG_W-1:0]   nbload_tag, nbload_inv_tag, nbload_data_tag;
   dec_pkg::reg_addr_t nbload_rd;
   dec_pkg::xlen_t     nbload_data;
   logic               nbload_credit;
   logic               halt_req, run_req, lsu_halt_idle, pause_wr;
   logic [PAUSE_W-1:0] pause_count;
   logic               halt_ack, run_ack, halt_status, pause_state;

   dec_pkg::xlen_t     model [dec_pkg::NUM_GPR];      // expected register contents
   logic [NBLOAD_DEPTH-1:0] pend_m;                   // tags in flight
   dec_pkg::reg_addr_t dest_m [NBLOAD_DEPTH];         // destination per tag
   logic               halted_m;                      // retire writes blocked
   int                 credit_cnt;                    // credit pulses seen
   row_t               tbl [$];

   tb_clk_gen #(.PERIOD(100)) u_clk (.clk(clk));

   dec_core #(.NBLOAD_DEPTH(NBLOAD_DEPTH), .PAUSE_W(PAUSE_W)) u_dut (.*);

   always @(posedge clk) begin
      if (!rst_n)
         credit_cnt <= 0;
      else if (nbload_credit)
         credit_cnt <= credit_cnt + 1;
   end

   task automatic stop_on_error(input string msg);
      $display("ERRORS FOUND");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_val(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp)
         else stop_on_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                      $time, what, got, exp));
   endtask

   // sel 0 halt_ack, 1 run_ack
   task automatic wait_high(input int sel, input string what);
      int n;
      n = 0;
      while (!(sel == 0 ? halt_ack : run_ack)) begin
         assert (n < TIMEOUT)
            else stop_on_error($sformatf("no %s within %0d cycles", what, TIMEOUT));
         @(negedge clk);
         n++;
      end
   endtask

   function automatic void add_row(input op_e op, input int a, input int b = 0,
                                   input int c = 0, input int d = 0);
      tbl.push_back('{op, a, b, c, d});
   endfunction

   task automatic release_pulses();
      wen0              = 1'b0;
      wen1              = 1'b0;
      nbload_valid      = 1'b0;
      nbload_inv_valid  = 1'b0;
      nbload_data_valid = 1'b0;
      halt_req          = 1'b0;
      run_req           = 1'b0;
      pause_wr          = 1'b0;
   endtask

   //**********************************************************
   // one table row per call
   //**********************************************************
   task automatic apply_row(input row_t r);
      dec_pkg::xlen_t d0;
      dec_pkg::xlen_t d1;
      int n;
      @(negedge clk);
      release_pulses();
      d0 = $urandom;
      d1 = $urandom;
      case (r.op)
         OP_WR: begin
            wen0   = r.c[0];
            wen1   = r.c[1];
            waddr0 = dec_pkg::reg_addr_t'(r.a);
            waddr1 = dec_pkg::reg_addr_t'(r.b);
            wd0    = d0;
            wd1    = d1;
            if (!halted_m) begin
               if (r.c[0] && r.a != 0) model[r.a] = d0;
               if (r.c[1] && r.b != 0) model[r.b] = d1;   // slot 1 wins
            end
         end
         OP_RD: begin
            raddr0 = dec_pkg::reg_addr_t'(r.a);
            raddr1 = dec_pkg::reg_addr_t'(r.b);
            raddr2 = dec_pkg::reg_addr_t'(r.c);
            raddr3 = dec_pkg::reg_addr_t'(r.d);
            @(negedge clk);                           // no write this cycle
            check_val("rd0", rd0, model[r.a]);
            check_val("rd1", rd1, model[r.b]);
            check_val("rd2", rd2, model[r.c]);
            check_val("rd3", rd3, model[r.d]);
         end
         OP_ISS: begin
            nbload_valid = 1'b1;
            nbload_tag   = TAG_W'(r.a);
            nbload_rd    = dec_pkg::reg_addr_t'(r.b);
            pend_m[r.a]  = 1'b1;
            dest_m[r.a]  = dec_pkg::reg_addr_t'(r.b);
         end
         OP_RET: begin
            nbload_data_valid = 1'b1;
            nbload_data_tag   = TAG_W'(r.a);
            nbload_data       = d0;
            if (pend_m[r.a]) begin                    // stale tags ignored
               if (dest_m[r.a] != '0) model[dest_m[r.a]] = d0;
               pend_m[r.a] = 1'b0;
            end
         end
         OP_INV: begin
            nbload_inv_valid = 1'b1;
            nbload_inv_tag   = TAG_W'(r.a);
            pend_m[r.a]      = 1'b0;                  // no write
         end
         OP_HALT: halt_req = 1'b1;
         OP_QUIET: begin
            lsu_halt_idle = r.c[0];                   // lsu side held for the window
            for (n = 0; n < r.a; n++) begin
               @(negedge clk);
               check_val("halt_ack while draining", 32'(halt_ack), 0);
               check_val("halt_status while draining", 32'(halt_status), 0);
            end
         end
         OP_IDLE: begin
            lsu_halt_idle = 1'b1;
            wait_high(0, "halt_ack");
            check_val("halt_status", 32'(halt_status), 1);
            halted_m = 1'b1;
            @(negedge clk);
            check_val("halt_ack one cycle later", 32'(halt_ack), 0);
         end
         OP_RUN: begin
            run_req = 1'b1;
            @(negedge clk);
            run_req = 1'b0;
            wait_high(1, "run_ack");
            check_val("halt_status after run", 32'(halt_status), 0);
            halted_m = 1'b0;
            @(negedge clk);
            check_val("run_ack one cycle later", 32'(run_ack), 0);
         end
         OP_PAUSE: begin
            pause_wr    = 1'b1;
            pause_count = PAUSE_W'(r.a);
            @(negedge clk);
            pause_wr = 1'b0;
            n = 0;
            while (pause_state) begin                 // count paused cycles
               assert (n < TIMEOUT)
                  else stop_on_error("pause_state never dropped");
               n++;
               @(negedge clk);
            end
            check_val("pause cycles", n, r.a);
         end
         OP_PHALT: begin
            pause_wr    = 1'b1;
            pause_count = PAUSE_W'(r.a);
            @(negedge clk);
            pause_wr = 1'b0;
            repeat (r.c) @(negedge clk);
            check_val("pause_state before halt", 32'(pause_state), 1);
            halt_req = 1'b1;
            @(negedge clk);
            halt_req = 1'b0;
            wait_high(0, "halt_ack");
            check_val("pause_state after halt", 32'(pause_state), 0);
            halted_m = 1'b1;
            @(negedge clk);
            check_val("halt_ack one cycle later", 32'(halt_ack), 0);
         end
         OP_CRD: check_val("credit pulses", credit_cnt, r.a);
         default: stop_on_error("unknown row in the stimulus table");
      endcase
   endtask

   initial begin
      void'($urandom(37109));
      // retire writes, collision, x0
      add_row(OP_WR, 3, 5, 3);
      add_row(OP_WR, 7, 7, 3);
      add_row(OP_WR, 0, 9, 3);
      add_row(OP_WR, 4, 0, 3);
      add_row(OP_RD, 3, 5, 7, 0);
      add_row(OP_RD, 9, 4, 0, 7);
      // four loads, out of order returns
      for (int t = 0; t < NBLOAD_DEPTH; t++) add_row(OP_ISS, t, 10 + t);
      add_row(OP_RET, 2);
      add_row(OP_RET, 0);
      add_row(OP_RET, 3);
      add_row(OP_RET, 1);
      add_row(OP_RD, 10, 11, 12, 13);
      add_row(OP_CRD, 4);
      // invalidate, then a stale return
      add_row(OP_ISS, 1, 14);
      add_row(OP_INV, 1);
      add_row(OP_RET, 1);
      add_row(OP_RD, 14, 14, 0, 0);
      add_row(OP_CRD, 5);
      // halt with a load pending
      add_row(OP_ISS, 2, 15);
      add_row(OP_HALT, 0);
      add_row(OP_QUIET, 4);                           // lsu busy, load pending
      add_row(OP_QUIET, 8, 0, 1);                     // lsu idle, load pending
      add_row(OP_RET, 2);
      add_row(OP_QUIET, 4);                           // lsu still busy
      add_row(OP_IDLE, 0);
      add_row(OP_WR, 15, 16, 3);                      // blocked
      add_row(OP_RD, 15, 16, 0, 0);
      add_row(OP_RUN, 0);
      add_row(OP_WR, 15, 16, 3);
      add_row(OP_RD, 15, 16, 0, 0);
      add_row(OP_CRD, 6);
      // pause timer
      add_row(OP_PAUSE, 5);
      add_row(OP_PAUSE, 1);
      add_row(OP_PAUSE, 0);
      add_row(OP_PHALT, 20, 0, 3);
      add_row(OP_RUN, 0);

      foreach (model[i]) model[i] = '0;
      pend_m        = '0;
      halted_m      = 1'b0;
      raddr0        = '0;
      raddr1        = '0;
      raddr2        = '0;
      raddr3        = '0;
      waddr0        = '0;
      waddr1        = '0;
      wd0           = '0;
      wd1           = '0;
      nbload_tag    = '0;
      nbload_rd     = '0;
      nbload_inv_tag  = '0;
      nbload_data_tag = '0;
      nbload_data   = '0;
      lsu_halt_idle = 1'b0;
      pause_count   = '0;
      release_pulses();
      rst_n = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      check_val("status after reset",
                32'({halt_ack, run_ack, halt_status, pause_state, nbload_credit}), 0);

      foreach (tbl[i]) apply_row(tbl[i]);
      @(negedge clk);
      release_pulses();

      if (u_dut.u_props.fail_cnt == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         stop_on_error("a bound handshake property failed during the run");
      end
   end

endmodule

/* tests/dec_props.sv */
`timescale 1ns/10ps

module dec_props #(
   parameter int NBLOAD_DEPTH = 4                     // load tags
) (
   input logic clk,
   input logic rst_n,
   input logic halt_ack,
   input logic run_ack,
   input logic halt_status,
   input logic pending_any,
   input logic nbload_valid,
   input logic nbload_credit,
   input logic nbload_data_valid,
   input logic nbload_inv_valid
);

   int credits;                                       // credits held by the lsu
   int fail_cnt;                                      // read back by the testbench

   initial fail_cnt = 0;

   always @(posedge clk) begin
      if (!rst_n)
         credits <= NBLOAD_DEPTH;                     // full pool after reset
      else
         credits <= credits - int'(nbload_valid) + int'(nbload_credit);
   end

   //**********************************************************
   // handshake rules
   //**********************************************************
   acks_apart: assert property (@(posedge clk) disable iff (!rst_n)
      !(halt_ack && run_ack))
      else begin
         fail_cnt++;
         $error("halt_ack and run_ack high in the same cycle");
      end

   halted_drained: assert property (@(posedge clk) disable iff (!rst_n)
      halt_status |-> !pending_any)                   // loads drain before halt
      else begin
         fail_cnt++;
         $error("halt_status high with a load still pending");
      end

   issue_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
      nbload_valid |-> (credits > 0))
      else begin
         fail_cnt++;
         $error("load issued with no credit left");
      end

   one_free: assert property (@(posedge clk) disable iff (!rst_n)
      !(nbload_data_valid && nbload_inv_valid))       // lsu never frees two tags
      else begin
         fail_cnt++;
         $error("data return and invalidate in the same cycle");
      end

endmodule

bind dec_core dec_props #(.NBLOAD_DEPTH(NBLOAD_DEPTH)) u_props (
   .clk               (clk),
   .rst_n             (rst_n),
   .halt_ack          (halt_ack),
   .run_ack           (run_ack),
   .halt_status       (halt_status),
   .pending_any       (pending_any),
   .nbload_valid      (nbload_valid),
   .nbload_credit     (nbload_credit),
   .nbload_data_valid (nbload_data_valid),
   .nbload_inv_valid  (nbload_inv_valid)
);

/* tests/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int PERIOD = 100                         // ns
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;                   // 50 ns per phase

endmodule

/* hw/dec_core.sv */
`timescale 1ns/10ps

module dec_core #(
   parameter int NBLOAD_DEPTH = 4,                    // load tags
   parameter int PAUSE_W      = 16                    // pause count width
) (
   input  logic clk,
   input  logic rst_n,

   // register file reads
   input  dec_pkg::reg_addr_t raddr0,
   input  dec_pkg::reg_addr_t raddr1,
   input  dec_pkg::reg_addr_t raddr2,
   input  dec_pkg::reg_addr_t raddr3,
   output dec_pkg::xlen_t     rd0,
   output dec_pkg::xlen_t     rd1,
   output dec_pkg::xlen_t     rd2,
   output dec_pkg::xlen_t     rd3,

   // retire writes
   input  logic               wen0,
   input  logic               wen1,
   input  dec_pkg::reg_addr_t waddr0,
   input  dec_pkg::reg_addr_t waddr1,
   input  dec_pkg::xlen_t     wd0,
   input  dec_pkg::xlen_t     wd1,

   // nonblocking loads
   input  logic                                      nbload_valid,
   input  logic [$clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2)-1:0] nbload_tag,
   input  dec_pkg::reg_addr_t                        nbload_rd,
   input  logic                                      nbload_inv_valid,
   input  logic [$clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2)-1:0] nbload_inv_tag,
   input  logic                                      nbload_data_valid,
   input  logic [$clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2)-1:0] nbload_data_tag,
   input  dec_pkg::xlen_t                            nbload_data,
   output logic                                      nbload_credit,

   // halt, run and pause
   input  logic               halt_req,
   input  logic               run_req,
   input  logic               lsu_halt_idle,
   input  logic               pause_wr,
   input  logic [PAUSE_W-1:0] pause_count,
   output logic               halt_ack,
   output logic               run_ack,
   output logic               halt_status,
   output logic               pause_state
);

   logic               load_wen;                      // load writeback port
   dec_pkg::reg_addr_t load_waddr;
   dec_pkg::xlen_t     load_wdata;
   logic               pending_any;                   // loads in flight
   logic               halted;                        // retire block

   dec_pause_if #(.PAUSE_W(PAUSE_W)) pause_if ();     // fsm to timer

   //**********************************************************
   // instances
   //**********************************************************
   dec_gpr_ctl u_gpr (.*);                            // architectural regs

   dec_nbload_ctl #(.NBLOAD_DEPTH(NBLOAD_DEPTH)) u_nbload (.*);

   dec_halt_ctl #(.PAUSE_W(PAUSE_W)) u_halt (
      .*,
      .pif (pause_if.ctl)
   );

   dec_pause_timer #(.PAUSE_W(PAUSE_W)) u_pause (
      .clk   (clk),
      .rst_n (rst_n),
      .pif   (pause_if.timer)
   );

endmodule

/* hw/dec_pause_timer.sv */
`timescale 1ns/10ps

module dec_pause_timer #(
   parameter int PAUSE_W = 16                         // pause count width
) (
   input  logic       clk,
   input  logic       rst_n,
   dec_pause_if.timer pif
);

   logic [PAUSE_W-1:0] cnt_q;                         // cycles left in pause

   //**********************************************************
   // down counter
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q <= '0;                                 // idle
      end else if (pif.pause_clear) begin
         cnt_q <= '0;                                 // halt aborts pause
      end else if (pif.pause_load) begin
         cnt_q <= pif.pause_count;                    // first paused cycle next
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // count hits zero at the end of this cycle
   assign pif.pause_done = (cnt_q == PAUSE_W'(1));

endmodule

/* hw/dec_halt_ctl.sv */
`timescale 1ns/10ps

module dec_halt_ctl #(
   parameter int PAUSE_W = 16                         // pause count width
) (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               halt_req,               // halt request
   input  logic               run_req,                // run request
   input  logic               lsu_halt_idle,          // lsu quiet enough to halt

   input  logic               pause_wr,               // pause register write
   input  logic [PAUSE_W-1:0] pause_count,            // cycles to pause

   input  logic               pending_any,            // loads still in flight

   output logic               halt_ack,               // pulse on entry to halted
   output logic               run_ack,                // pulse on return to run
   output logic               halt_status,            // level while halted
   output logic               pause_state,            // level while paused
   output logic               halted,                 // blocks retire writes

   dec_pause_if.ctl           pif
);

   dec_pkg::halt_state_e state_q;
   dec_pkg::halt_state_e state_d;

   logic halt_ack_q;
   logic run_ack_q;
   logic pause_start;                                 // accepted pause write
   logic pause_abort;                                 // halt during pause
   logic go_halted;                                   // halting drained
   logic go_run;                                      // run request accepted

   assign pause_start = (state_q == dec_pkg::st_run) & pause_wr & ~halt_req &
                        (pause_count != '0);          // zero count ignored
   assign pause_abort = (state_q == dec_pkg::st_pause) & halt_req;
   assign go_halted   = (state_q == dec_pkg::st_halting) & lsu_halt_idle & ~pending_any;
   assign go_run      = (state_q == dec_pkg::st_halted) & run_req;

   //**********************************************************
   // next state
   //**********************************************************
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         dec_pkg::st_run: begin
            if (halt_req)
               state_d = dec_pkg::st_halting;         // halt beats pause
            else if (pause_start)
               state_d = dec_pkg::st_pause;
         end
         dec_pkg::st_pause: begin
            if (halt_req)
               state_d = dec_pkg::st_halting;         // timer cleared too
            else if (pif.pause_done)
               state_d = dec_pkg::st_run;
         end
         dec_pkg::st_halting: begin
            if (go_halted)
               state_d = dec_pkg::st_halted;
         end
         dec_pkg::st_halted: begin
            if (go_run)
               state_d = dec_pkg::st_run;
         end
         default: state_d = dec_pkg::st_run;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= dec_pkg::st_run;
         halt_ack_q <= 1'b0;
         run_ack_q  <= 1'b0;
      end else begin
         state_q    <= state_d;
         halt_ack_q <= go_halted;                     // lines up with st_halted
         run_ack_q  <= go_run;                        // lines up with st_run
      end
   end

   assign halt_ack    = halt_ack_q;
   assign run_ack     = run_ack_q;
   assign halt_status = (state_q == dec_pkg::st_halted);
   assign halted      = (state_q == dec_pkg::st_halted);
   assign pause_state = (state_q == dec_pkg::st_pause);

   // timer control
   assign pif.pause_load  = pause_start;
   assign pif.pause_count = pause_count;
   assign pif.pause_clear = pause_abort;

endmodule

/* hw/dec_nbload_ctl.sv */
`timescale 1ns/10ps

module dec_nbload_ctl #(
   parameter int NBLOAD_DEPTH = 4                     // outstanding load tags
) (
   input  logic clk,
   input  logic rst_n,

   // issue from lsu
   input  logic                                      nbload_valid,
   input  logic [$clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2)-1:0] nbload_tag,
   input  dec_pkg::reg_addr_t                        nbload_rd,     // destination

   // invalidate from lsu
   input  logic                                      nbload_inv_valid,
   input  logic [$clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2)-1:0] nbload_inv_tag,

   // data return from lsu
   input  logic                                      nbload_data_valid,
   input  logic [$clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2)-1:0] nbload_data_tag,
   input  dec_pkg::xlen_t                            nbload_data,

   // load write port to the register file
   output logic                                      load_wen,
   output dec_pkg::reg_addr_t                        load_waddr,
   output dec_pkg::xlen_t                            load_wdata,

   output logic                                      nbload_credit, // one per freed tag
   output logic                                      pending_any    // any tag in flight
);

   localparam int TAG_W = $clog2(NBLOAD_DEPTH > 1 ? NBLOAD_DEPTH : 2);

   logic [NBLOAD_DEPTH-1:0] valid_q;                  // tag in use
   dec_pkg::reg_addr_t      rd_q [NBLOAD_DEPTH];      // destination per tag
   logic                    credit_q;                 // registered credit pulse

   logic data_in_rng;                                 // tag within table
   logic inv_in_rng;
   logic data_hit;                                    // return names a pending tag
   logic inv_hit;                                     // invalidate names a pending tag

   assign data_in_rng = 32'(nbload_data_tag) < NBLOAD_DEPTH;
   assign inv_in_rng  = 32'(nbload_inv_tag) < NBLOAD_DEPTH;

   assign data_hit = nbload_data_valid & data_in_rng & valid_q[nbload_data_tag];
   assign inv_hit  = nbload_inv_valid & inv_in_rng & valid_q[nbload_inv_tag];

   //**********************************************************
   // tag table
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q  <= '0;                              // all tags free
         credit_q <= 1'b0;
      end else begin
         credit_q <= data_hit | inv_hit;              // at most one free per cycle
         if (data_hit)
            valid_q[nbload_data_tag] <= 1'b0;         // written back
         if (inv_hit)
            valid_q[nbload_inv_tag] <= 1'b0;          // dropped, no write
         if (nbload_valid)
            valid_q[nbload_tag] <= 1'b1;              // new load in flight
      end
   end

   always_ff @(posedge clk) begin
      if (nbload_valid)
         rd_q[nbload_tag] <= nbload_rd;               // capture destination
   end

   // writeback in the cycle of the return, x0 dropped by the gpr
   assign load_wen   = data_hit;
   assign load_waddr = rd_q[nbload_data_tag[TAG_W-1:0]];
   assign load_wdata = nbload_data;

   assign nbload_credit = credit_q;
   assign pending_any   = |valid_q;

endmodule

/* hw/dec_gpr_ctl.sv */
`timescale 1ns/10ps

module dec_gpr_ctl (
   input  logic              clk,
   input  logic              rst_n,

   input  dec_pkg::reg_addr_t raddr0,                 // i0 rs1
   input  dec_pkg::reg_addr_t raddr1,                 // i0 rs2
   input  dec_pkg::reg_addr_t raddr2,                 // i1 rs1
   input  dec_pkg::reg_addr_t raddr3,                 // i1 rs2
   output dec_pkg::xlen_t     rd0,
   output dec_pkg::xlen_t     rd1,
   output dec_pkg::xlen_t     rd2,
   output dec_pkg::xlen_t     rd3,

   input  logic              wen0,                    // slot 0 retire
   input  logic              wen1,                    // slot 1 retire
   input  dec_pkg::reg_addr_t waddr0,
   input  dec_pkg::reg_addr_t waddr1,
   input  dec_pkg::xlen_t     wd0,
   input  dec_pkg::xlen_t     wd1,

   input  logic              load_wen,                // nonblocking load return
   input  dec_pkg::reg_addr_t load_waddr,
   input  dec_pkg::xlen_t     load_wdata,

   input  logic              halted                   // blocks retire writes
);

   dec_pkg::xlen_t gpr [dec_pkg::NUM_GPR-1:1];        // x0 has no storage

   logic wen0_eff;                                    // slot 0 after halt mask
   logic wen1_eff;                                    // slot 1 after halt mask

   assign wen0_eff = wen0 & ~halted;
   assign wen1_eff = wen1 & ~halted;

   //**********************************************************
   // write ports, slot 1 over slot 0 over load data
   //**********************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < dec_pkg::NUM_GPR; i++) begin
            gpr[i] <= '0;                             // all regs clear
         end
      end else begin
         for (int i = 1; i < dec_pkg::NUM_GPR; i++) begin
            if (wen1_eff && (waddr1 == dec_pkg::reg_addr_t'(i)))
               gpr[i] <= wd1;                         // youngest retire wins
            else if (wen0_eff && (waddr0 == dec_pkg::reg_addr_t'(i)))
               gpr[i] <= wd0;
            else if (load_wen && (load_waddr == dec_pkg::reg_addr_t'(i)))
               gpr[i] <= load_wdata;                  // lowest priority
         end
      end
   end

   // read ports, x0 hardwired to zero
   assign rd0 = (raddr0 == '0) ? '0 : gpr[raddr0];
   assign rd1 = (raddr1 == '0) ? '0 : gpr[raddr1];
   assign rd2 = (raddr2 == '0) ? '0 : gpr[raddr2];
   assign rd3 = (raddr3 == '0) ? '0 : gpr[raddr3];

endmodule

/* hw/dec_pause_if.sv */
`timescale 1ns/10ps

interface dec_pause_if #(
   parameter int PAUSE_W = 16                         // pause count width
);

   logic               pause_load;                    // start the count
   logic [PAUSE_W-1:0] pause_count;                   // cycles to pause
   logic               pause_clear;                   // abort on halt
   logic               pause_done;                    // last paused cycle

   modport ctl   (output pause_load, pause_count, pause_clear,
                  input  pause_done);                 // halt fsm side

   modport timer (input  pause_load, pause_count, pause_clear,
                  output pause_done);                 // down counter side

endinterface

/* hw/dec_pkg.sv */
package dec_pkg;

   //**********************************************************
   // datapath widths
   //**********************************************************
   localparam int XLEN       = 32;                    // data word
   localparam int NUM_GPR    = 32;                    // x0..x31
   localparam int REG_ADDR_W = 5;                     // log2 of NUM_GPR

   typedef logic [XLEN-1:0]       xlen_t;             // register data
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;         // register index

   //**********************************************************
   // halt/run state machine
   //**********************************************************
   typedef enum logic [1:0] {
      st_run     = 2'b00,                             // normal retire
      st_pause   = 2'b01,                             // pause timer running
      st_halting = 2'b10,                             // draining loads
      st_halted  = 2'b11                              // stopped, retire blocked
   } halt_state_e;

   // st_halting only waits on the load side
   // st_pause returns to st_run by itself
   // st_halted leaves only on a run request

endpackage
